// ==== compile.f ====
verilog/awb_pkg.sv
verilog/video_bus_if.sv
verilog/frame_stats.sv
verilog/gain_divider.sv
verilog/gain_apply.sv
verilog/awb_top.sv
tests/awb_tb.sv

// ==== tests/awb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module awb_tb
    import awb_pkg::*;
();

    localparam int num_frames   = 6;
    localparam int line_pixels  = 16;
    localparam int line_count   = 4;
    localparam int line_gap     = 4;
    localparam int vsync_cycles = 2;
    localparam int blank_cycles = 58;
    localparam int frame_cycles = line_count * (line_pixels + line_gap)
                                  + vsync_cycles + blank_cycles;

    logic   clk;
    logic   reset_n;
    logic   in_vsync;
    logic   in_hsync;
    logic   in_den;
    pixel_t in_r;
    pixel_t in_g;
    pixel_t in_b;
    logic   out_vsync;
    logic   out_hsync;
    logic   out_den;
    pixel_t out_r;
    pixel_t out_g;
    pixel_t out_b;

    // base {r, g, b} per frame
    logic [23:0] frame_table [0:num_frames-1];

    // expected outputs, {vsync, hsync, den, r, g, b}, one and two samples back
    logic [26:0] pipe [0:1];

    int     seed;
    int     gain_r_model;
    int     gain_b_model;
    longint sum_r;
    longint sum_g;
    longint sum_b;
    int     clip_count;

    awb_top #(
        .source_h (16),
        .source_v (4)
    ) dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_vsync  (in_vsync),
        .in_hsync  (in_hsync),
        .in_den    (in_den),
        .in_r      (in_r),
        .in_g      (in_g),
        .in_b      (in_b),
        .out_vsync (out_vsync),
        .out_hsync (out_hsync),
        .out_den   (out_den),
        .out_r     (out_r),
        .out_g     (out_g),
        .out_b     (out_b)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // gray-world gain in Q8.8, unity for an empty channel
    function automatic int gray_gain(input longint green, input longint chan);
        longint q;
        if (chan == 0) begin
            return 256;
        end
        q = (green * 256) / chan;
        if (q > 65535) begin
            return 65535;
        end
        return int'(q);
    endfunction

    // integer part of sample times gain, clipped to 8 bits
    function automatic pixel_t scale(input pixel_t p, input int gain);
        int v;
        v = (int'(p) * gain) / 256;
        if (v > 255) begin
            return 8'hff;
        end
        return v[7:0];
    endfunction

    function automatic pixel_t noisy_sample(input pixel_t base);
        int offset;
        if (base == 0) begin
            return 8'd0;
        end
        offset = $random(seed);
        return base + pixel_t'(offset & 7);
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "output mismatch");
        end
    endtask

    // one clock of stimulus, checking what was sent two samples earlier
    task automatic drive_sample(input logic vs, input logic hs, input logic de,
                                input pixel_t r, input pixel_t g, input pixel_t b);
        logic [26:0] expected;
        @(negedge clk);
        expected = pipe[1];
        check_value("out_vsync", {7'd0, expected[26]}, {7'd0, out_vsync});
        check_value("out_hsync", {7'd0, expected[25]}, {7'd0, out_hsync});
        check_value("out_den", {7'd0, expected[24]}, {7'd0, out_den});
        check_value("out_r", expected[23:16], out_r);
        check_value("out_g", expected[15:8], out_g);
        check_value("out_b", expected[7:0], out_b);
        pipe[1] = pipe[0];
        in_vsync = vs;
        in_hsync = hs;
        in_den   = de;
        in_r     = r;
        in_g     = g;
        in_b     = b;
        pipe[0] = {vs, hs, de, scale(r, gain_r_model), g, scale(b, gain_b_model)};
        if (de) begin
            sum_r += r;
            sum_g += g;
            sum_b += b;
        end
    endtask

    task automatic send_frame(input int idx);
        logic [23:0] base;
        pixel_t      r;
        pixel_t      g;
        pixel_t      b;
        base = frame_table[idx];
        for (int line = 0; line < line_count; line++) begin
            for (int px = 0; px < line_pixels; px++) begin
                r = noisy_sample(base[23:16]);
                g = noisy_sample(base[15:8]);
                b = noisy_sample(base[7:0]);
                if (scale(r, gain_r_model) == 8'hff) begin
                    clip_count++;
                end
                drive_sample(1'b0, 1'b1, 1'b1, r, g, b);
            end
            repeat (line_gap) drive_sample(1'b0, 1'b0, 1'b0, 8'd0, 8'd0, 8'd0);
        end
        // frame boundary, these gains hold for every pixel of the next frame
        gain_r_model = gray_gain(sum_g, sum_r);
        gain_b_model = gray_gain(sum_g, sum_b);
        sum_r = 0;
        sum_g = 0;
        sum_b = 0;
        repeat (vsync_cycles) drive_sample(1'b1, 1'b0, 1'b0, 8'd0, 8'd0, 8'd0);
        repeat (blank_cycles) drive_sample(1'b0, 1'b0, 1'b0, 8'd0, 8'd0, 8'd0);
    endtask

    initial begin
        seed         = 32'h7147;
        reset_n      = 1'b0;
        in_vsync     = 1'b0;
        in_hsync     = 1'b0;
        in_den       = 1'b0;
        in_r         = 8'd0;
        in_g         = 8'd0;
        in_b         = 8'd0;
        pipe[0]      = '0;
        pipe[1]      = '0;
        gain_r_model = 256;
        gain_b_model = 256;
        sum_r        = 0;
        sum_g        = 0;
        sum_b        = 0;
        clip_count   = 0;

        // unity, gray-world source, low red, clipping target, no red, recovery
        frame_table[0] = {8'd100, 8'd100, 8'd100};
        frame_table[1] = {8'd60, 8'd120, 8'd200};
        frame_table[2] = {8'd20, 8'd150, 8'd100};
        frame_table[3] = {8'd200, 8'd150, 8'd100};
        frame_table[4] = {8'd0, 8'd150, 8'd100};
        frame_table[5] = {8'd90, 8'd140, 8'd110};

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        for (int f = 0; f < num_frames; f++) begin
            if (f == 5) begin
                // active red gain after a frame without red
                assert (dut.u_apply.gain_r_q === 16'h0100) else begin
                    $display("FAIL gain_r expected %h actual %h", 16'h0100,
                             dut.u_apply.gain_r_q);
                    $display("Errors found");
                    $fatal(1, "gain check");
                end
            end
            send_frame(f);
            if (f == 3) begin
                assert (clip_count > 0) else begin
                    $display("no red sample reached the clipping limit in frame 3");
                    $display("Errors found");
                    $fatal(1, "stimulus check");
                end
            end
        end

        // drain the two pipeline stages
        repeat (2) drive_sample(1'b0, 1'b0, 1'b0, 8'd0, 8'd0, 8'd0);

        $display("No errors");
        $finish;
    end

    // watchdog
    initial begin
        repeat (num_frames * frame_cycles + 100) @(posedge clk);
        $display("timeout: the frames did not finish within %0d cycles",
                 num_frames * frame_cycles + 100);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== verilog/awb_pkg.sv ====
`default_nettype none

package awb_pkg;

    // one colour sample of the RGB stream
    typedef logic [7:0] pixel_t;

    // unsigned Q8.8, 8 integer bits and 8 fraction bits
    typedef logic [15:0] gain_t;

    // 1.0 in Q8.8
    localparam gain_t gain_unity = 16'h0100;

    // saturation value for a quotient that does not fit 16 bits
    localparam gain_t gain_max = 16'hffff;

    // serial divider control
    typedef enum logic {
        div_idle,
        div_busy
    } div_state_t;

endpackage

`default_nettype wire

// ==== verilog/awb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module awb_top
    import awb_pkg::*;
#(
    parameter int source_h = 512,
    parameter int source_v = 512
) (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   in_vsync,
    input  logic   in_hsync,
    input  logic   in_den,
    input  pixel_t in_r,
    input  pixel_t in_g,
    input  pixel_t in_b,
    output logic   out_vsync,
    output logic   out_hsync,
    output logic   out_den,
    output pixel_t out_r,
    output pixel_t out_g,
    output pixel_t out_b
);

    // room for a full frame of 255 samples per channel
    localparam int sum_width = $clog2(source_h * source_v * 255) + 1;

    logic [sum_width-1:0] sum_r;
    logic [sum_width-1:0] sum_g;
    logic [sum_width-1:0] sum_b;
    logic                 stats_valid;

    gain_t                gain_r;
    gain_t                gain_b;
    logic                 gain_r_ready;
    logic                 gain_b_ready;

    video_bus_if vin ();

    assign vin.vsync = in_vsync;
    assign vin.hsync = in_hsync;
    assign vin.den   = in_den;
    assign vin.r     = in_r;
    assign vin.g     = in_g;
    assign vin.b     = in_b;

    frame_stats #(
        .sum_width (sum_width)
    ) u_stats (
        .clk         (clk),
        .reset_n     (reset_n),
        .vin         (vin),
        .sum_r       (sum_r),
        .sum_g       (sum_g),
        .sum_b       (sum_b),
        .stats_valid (stats_valid)
    );

    // gain_r = (sum_g << 8) / sum_r
    gain_divider #(
        .sum_width (sum_width)
    ) div_r (
        .clk           (clk),
        .reset_n       (reset_n),
        .start         (stats_valid),
        .dividend_base (sum_g),
        .divisor       (sum_r),
        .gain          (gain_r),
        .gain_ready    (gain_r_ready)
    );

    gain_divider #(
        .sum_width (sum_width)
    ) div_b (
        .clk           (clk),
        .reset_n       (reset_n),
        .start         (stats_valid),
        .dividend_base (sum_g),
        .divisor       (sum_b),
        .gain          (gain_b),
        .gain_ready    (gain_b_ready)
    );

    gain_apply u_apply (
        .clk          (clk),
        .reset_n      (reset_n),
        .vin          (vin),
        .gain_r       (gain_r),
        .gain_b       (gain_b),
        .gain_r_ready (gain_r_ready),
        .gain_b_ready (gain_b_ready),
        .vsync        (out_vsync),
        .hsync        (out_hsync),
        .den          (out_den),
        .r            (out_r),
        .g            (out_g),
        .b            (out_b)
    );

endmodule

`default_nettype wire

// ==== verilog/frame_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_stats #(
    parameter int sum_width = 27
) (
    input  logic                 clk,
    input  logic                 reset_n,
    video_bus_if.sink            vin,
    output logic [sum_width-1:0] sum_r,
    output logic [sum_width-1:0] sum_g,
    output logic [sum_width-1:0] sum_b,
    output logic                 stats_valid
);

    logic                 vsync_d;
    logic                 frame_edge;
    logic [sum_width-1:0] acc_r;
    logic [sum_width-1:0] acc_g;
    logic [sum_width-1:0] acc_b;

    // start of next frame, vsync going high
    assign frame_edge = vin.vsync & ~vsync_d;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vsync_d <= 1'b0;
        end else begin
            vsync_d <= vin.vsync;
        end
    end

    // running totals over the active pixels
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc_r <= '0;
            acc_g <= '0;
            acc_b <= '0;
        end else if (frame_edge) begin
            // restart for the new frame, den in this cycle is dropped
            acc_r <= '0;
            acc_g <= '0;
            acc_b <= '0;
        end else if (vin.den) begin
            acc_r <= acc_r + {{(sum_width-8){1'b0}}, vin.r};
            acc_g <= acc_g + {{(sum_width-8){1'b0}}, vin.g};
            acc_b <= acc_b + {{(sum_width-8){1'b0}}, vin.b};
        end
    end

    // finished totals, held until the next frame edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_r       <= '0;
            sum_g       <= '0;
            sum_b       <= '0;
            stats_valid <= 1'b0;
        end else begin
            stats_valid <= frame_edge;
            if (frame_edge) begin
                sum_r <= acc_r;
                sum_g <= acc_g;
                sum_b <= acc_b;
            end
        end
    end

    // one strobe per frame edge, never a run of two
    a_single_strobe: assert property (
        @(posedge clk) disable iff (!reset_n)
        stats_valid |=> !stats_valid
    );

endmodule

`default_nettype wire

// ==== verilog/gain_apply.sv ====
`timescale 1ns/1ps
`default_nettype none

module gain_apply
    import awb_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    video_bus_if.sink   vin,
    input  gain_t       gain_r,
    input  gain_t       gain_b,
    input  logic        gain_r_ready,
    input  logic        gain_b_ready,
    output logic        vsync,
    output logic        hsync,
    output logic        den,
    output pixel_t      r,
    output pixel_t      g,
    output pixel_t      b
);

    gain_t        gain_r_q;
    gain_t        gain_b_q;

    logic         s1_vsync;
    logic         s1_hsync;
    logic         s1_den;
    pixel_t       s1_r;
    pixel_t       s1_g;
    pixel_t       s1_b;

    logic [23:0]  prod_r;
    logic [23:0]  prod_b;
    logic         ovf_r;
    logic         ovf_b;

    // active gains, replaced only on a divider done pulse
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            gain_r_q <= gain_unity;
            gain_b_q <= gain_unity;
        end else begin
            if (gain_r_ready) begin
                gain_r_q <= gain_r;
            end
            if (gain_b_ready) begin
                gain_b_q <= gain_b;
            end
        end
    end

    // stage one
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_vsync <= 1'b0;
            s1_hsync <= 1'b0;
            s1_den   <= 1'b0;
            s1_r     <= '0;
            s1_g     <= '0;
            s1_b     <= '0;
        end else begin
            s1_vsync <= vin.vsync;
            s1_hsync <= vin.hsync;
            s1_den   <= vin.den;
            s1_r     <= vin.r;
            s1_g     <= vin.g;
            s1_b     <= vin.b;
        end
    end

    // 8 x 16 product, integer part sits in bits 23:8
    assign prod_r = s1_r * gain_r_q;
    assign prod_b = s1_b * gain_b_q;
    assign ovf_r  = |prod_r[23:16];
    assign ovf_b  = |prod_b[23:16];

    // stage two, clip and align with green and syncs
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vsync <= 1'b0;
            hsync <= 1'b0;
            den   <= 1'b0;
            r     <= '0;
            g     <= '0;
            b     <= '0;
        end else begin
            vsync <= s1_vsync;
            hsync <= s1_hsync;
            den   <= s1_den;
            r     <= ovf_r ? 8'hff : prod_r[15:8];
            g     <= s1_g;
            b     <= ovf_b ? 8'hff : prod_b[15:8];
        end
    end

    a_clip_r: assert property (
        @(posedge clk) disable iff (!reset_n)
        ovf_r |=> (r == 8'hff)
    );

endmodule

`default_nettype wire

// ==== verilog/gain_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module gain_divider
    import awb_pkg::*;
#(
    parameter int sum_width = 27
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start,
    input  logic [sum_width-1:0] dividend_base,
    input  logic [sum_width-1:0] divisor,
    output gain_t                gain,
    output logic                 gain_ready
);

    // dividend carries 8 extra fraction bits
    localparam int dvd_width = sum_width + 8;
    localparam int cnt_width = $clog2(sum_width + 9);
    localparam logic [cnt_width-1:0] last_cnt = cnt_width'(sum_width + 8);

    div_state_t           state;
    logic [cnt_width-1:0] cnt;

    logic [sum_width-1:0] div_q;
    logic [sum_width-1:0] rem;
    logic [dvd_width-1:0] quo;

    logic [sum_width:0]   shifted;
    logic [sum_width:0]   trial;
    logic                 fits;
    logic                 div_zero;
    logic                 overflow;

    // one restoring step: bring in the next dividend bit, try a subtract
    assign shifted = {rem, quo[dvd_width-1]};
    assign trial   = shifted - {1'b0, div_q};
    assign fits    = shifted >= {1'b0, div_q};

    assign div_zero = (div_q == '0);
    assign overflow = |quo[dvd_width-1:16];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= div_idle;
            cnt        <= '0;
            gain       <= gain_unity;
            gain_ready <= 1'b0;
        end else begin
            gain_ready <= 1'b0;
            case (state)
                div_idle: begin
                    if (start) begin
                        state <= div_busy;
                        cnt   <= '0;
                    end
                end
                div_busy: begin
                    if (cnt == last_cnt) begin
                        // finish cycle
                        state      <= div_idle;
                        gain_ready <= 1'b1;
                        if (div_zero) begin
                            gain <= gain_unity;
                        end else if (overflow) begin
                            gain <= gain_max;
                        end else begin
                            gain <= quo[15:0];
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= div_idle;
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (state == div_idle && start) begin
            div_q <= divisor;
            rem   <= '0;
            quo   <= {dividend_base, 8'd0};
        end else if (state == div_busy && cnt != last_cnt) begin
            rem <= fits ? trial[sum_width-1:0] : shifted[sum_width-1:0];
            quo <= {quo[dvd_width-2:0], fits};
        end
    end

    // done pulse follows exactly the busy to idle transition
    a_ready_on_exit: assert property (
        @(posedge clk) disable iff (!reset_n)
        gain_ready == (state == div_idle && $past(state) == div_busy)
    );

    a_state_known: assert property (
        @(posedge clk) disable iff (!reset_n)
        !$isunknown(state)
    );

endmodule

`default_nettype wire

// ==== verilog/video_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface video_bus_if
    import awb_pkg::*;
();

    // level syncs and data enable
    logic   vsync;
    logic   hsync;
    logic   den;

    // parallel colour data, valid while den is high
    pixel_t r;
    pixel_t g;
    pixel_t b;

    modport source (
        output vsync, hsync, den,
        output r, g, b
    );

    modport sink (
        input vsync, hsync, den,
        input r, g, b
    );

endinterface

`default_nettype wire
